/* logic/mem_to_handshake_fifo.sv */
// Memory to handshake reader
// Wrapping address sweep with an in-flight guard feeding the FIFO
`timescale 1ns/1ns
`include "stream_defs.svh"

module mem_to_handshake_fifo (
    input  logic                       clk_i,
    input  logic                       rst_n_i,
    input  logic                       en_i,
    input  logic                       flush_i,
    input  logic [`STREAM_ADDR_W-1:0]  addr_upper_bound_i,
    output stream_pkg::mem_req_t       mem_req_o,
    input  stream_pkg::mem_rsp_t       mem_rsp_i,
    input  logic [`STREAM_USAGE_W-1:0] fifo_usage_i,
    input  logic                       fifo_empty_i,
    output logic                       fifo_push_o,
    output logic                       fifo_pop_o,
    input  logic                       data_ready_i,
    output logic                       data_valid_o
);

    localparam int USAGE_W = `STREAM_USAGE_W;

    // Room threshold, one bit wider than usage to hold usage plus in-flight
    localparam logic [USAGE_W:0] DEPTH_CMP = (USAGE_W + 1)'(`STREAM_DEPTH);

    // Sweep address and outstanding read marker
    logic [`STREAM_ADDR_W-1:0] raddr_q;
    logic [`STREAM_ADDR_W-1:0] raddr_next;
    logic                      in_flight_q;

    // Slots already claimed in the FIFO
    logic [USAGE_W:0]          committed;
    logic                      has_room;
    logic                      ren;
    logic                      valid;

    assign committed = (USAGE_W + 1)'(fifo_usage_i) + (USAGE_W + 1)'(in_flight_q);
    assign has_room  = (committed < DEPTH_CMP);

    // Issue a read only when the response is sure to fit
    assign ren = en_i & ~flush_i & has_room;

    // Inclusive bound, back to 0 after it
    assign raddr_next = (raddr_q == addr_upper_bound_i) ? '0 : raddr_q + 1'b1;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            raddr_q     <= '0;
            in_flight_q <= 1'b0;
        end else begin
            // ren is low during flush so this also clears the marker
            in_flight_q <= ren;
            if (flush_i) begin
                raddr_q <= '0;
            end else if (ren) begin
                raddr_q <= raddr_next;
            end
        end
    end

    assign mem_req_o.ren   = ren;
    assign mem_req_o.raddr = raddr_q;

    // Responses without a live request are stale and dropped
    assign fifo_push_o = mem_rsp_i.rvalid & in_flight_q;

    // Downstream handshake
    assign valid        = en_i & ~fifo_empty_i;
    assign data_valid_o = valid;
    assign fifo_pop_o   = data_ready_i & valid;

endmodule

/* logic/stream_defs.svh */
// Stream subsystem parameters
// FIFO depth and memory/data widths shared by the RTL and the testbench
`ifndef STREAM_DEFS_SVH
`define STREAM_DEFS_SVH

// Number of FIFO entries between memory and consumer
`define STREAM_DEPTH 4

// Weight memory address width (64 words)
`define STREAM_ADDR_W 6

// Width of one weight word
`define STREAM_DATA_W 32

// Occupancy counter width for 0 up to DEPTH inclusive
`define STREAM_USAGE_W $clog2(`STREAM_DEPTH + 1)

`endif

/* logic/stream_pkg.sv */
// Stream subsystem types
// Packed structs for the memory write, read request and read response
`include "stream_defs.svh"

package stream_pkg;

    // Loader write into the weight memory
    typedef struct packed {
        logic                      we;
        logic [`STREAM_ADDR_W-1:0] waddr;
        logic [`STREAM_DATA_W-1:0] wdata;
    } mem_wr_t;

    // Read request from the reader
    typedef struct packed {
        logic                      ren;
        logic [`STREAM_ADDR_W-1:0] raddr;
    } mem_req_t;

    // Read response, one cycle after the request
    typedef struct packed {
        logic                      rvalid;
        logic [`STREAM_DATA_W-1:0] rdata;
    } mem_rsp_t;

endpackage

/* logic/stream_top.sv */
// Weight stream top
// Weight SRAM, sweeping reader and output FIFO behind a valid/ready port
`timescale 1ns/1ns
`include "stream_defs.svh"

module stream_top (
    input  logic                       clk_i,
    input  logic                       rst_n_i,
    input  logic                       en_i,
    input  logic                       flush_i,
    input  logic [`STREAM_ADDR_W-1:0]  addr_upper_bound_i,
    // Loader write port, only while en_i is low
    input  stream_pkg::mem_wr_t        mem_wr_i,
    // Downstream handshake
    input  logic                       data_ready_i,
    output logic                       data_valid_o,
    output logic [`STREAM_DATA_W-1:0]  data_o,
    // Debug
    output logic [`STREAM_USAGE_W-1:0] debug_fifo_usage_o
);

    // Reader to memory
    stream_pkg::mem_req_t mem_req;
    // Memory to reader and FIFO
    stream_pkg::mem_rsp_t mem_rsp;

    // FIFO control and status
    logic                       fifo_push;
    logic                       fifo_pop;
    logic                       fifo_empty;
    logic [`STREAM_USAGE_W-1:0] fifo_usage;

    weight_sram sram_i (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .wr_i    (mem_wr_i),
        .req_i   (mem_req),
        .rsp_o   (mem_rsp)
    );

    mem_to_handshake_fifo reader_i (
        .clk_i              (clk_i),
        .rst_n_i            (rst_n_i),
        .en_i               (en_i),
        .flush_i            (flush_i),
        .addr_upper_bound_i (addr_upper_bound_i),
        .mem_req_o          (mem_req),
        .mem_rsp_i          (mem_rsp),
        .fifo_usage_i       (fifo_usage),
        .fifo_empty_i       (fifo_empty),
        .fifo_push_o        (fifo_push),
        .fifo_pop_o         (fifo_pop),
        .data_ready_i       (data_ready_i),
        .data_valid_o       (data_valid_o)
    );

    // Read data goes straight into the FIFO
    sync_fifo fifo_i (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .flush_i (flush_i),
        .push_i  (fifo_push),
        .data_i  (mem_rsp.rdata),
        .pop_i   (fifo_pop),
        .data_o  (data_o),
        .empty_o (fifo_empty),
        .usage_o (fifo_usage)
    );

    // Occupancy exported for debug
    assign debug_fifo_usage_o = fifo_usage;

endmodule

/* logic/sync_fifo.sv */
// Synchronous FIFO
// Circular buffer with registered storage, synchronous flush and usage count
`timescale 1ns/1ns
`include "stream_defs.svh"

module sync_fifo (
    input  logic                       clk_i,
    input  logic                       rst_n_i,
    input  logic                       flush_i,
    input  logic                       push_i,
    input  logic [`STREAM_DATA_W-1:0]  data_i,
    input  logic                       pop_i,
    output logic [`STREAM_DATA_W-1:0]  data_o,
    output logic                       empty_o,
    output logic [`STREAM_USAGE_W-1:0] usage_o
);

    localparam int DEPTH   = `STREAM_DEPTH;
    localparam int USAGE_W = `STREAM_USAGE_W;
    localparam int PTR_W   = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    // Count value when every entry holds data
    localparam logic [USAGE_W-1:0] FULL_CNT = USAGE_W'(DEPTH);
    // Index of the last entry, pointers wrap after it
    localparam logic [PTR_W-1:0] LAST_IDX = PTR_W'(DEPTH - 1);

    // Entry storage
    logic [`STREAM_DATA_W-1:0] mem_q [DEPTH];

    // Pointers and occupancy
    logic [PTR_W-1:0]   wr_ptr_q;
    logic [PTR_W-1:0]   rd_ptr_q;
    logic [USAGE_W-1:0] count_q;

    logic full;
    logic empty;
    logic do_push;
    logic do_pop;

    // Pointer advance with wrap at the last entry
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        logic [PTR_W-1:0] nxt;
        nxt = (ptr == LAST_IDX) ? '0 : ptr + 1'b1;
        return nxt;
    endfunction

    assign full  = (count_q == FULL_CNT);
    assign empty = (count_q == '0);

    // Pop only with data present
    assign do_pop  = pop_i & ~empty;
    // Push into a full FIFO only if a pop frees the slot
    assign do_push = push_i & (~full | do_pop);

    // Data storage, written on accepted pushes
    always_ff @(posedge clk_i) begin
        if (do_push && !flush_i) begin
            mem_q[wr_ptr_q] <= data_i;
        end
    end

    // Pointer and count control
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else if (flush_i) begin
            // Flush overrides any push or pop this cycle
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= next_ptr(wr_ptr_q);
            end
            if (do_pop) begin
                rd_ptr_q <= next_ptr(rd_ptr_q);
            end
            // Simultaneous push and pop leave the count alone
            case ({do_push, do_pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // Head entry straight from storage
    assign data_o  = mem_q[rd_ptr_q];
    assign empty_o = empty;
    assign usage_o = count_q;

endmodule

/* logic/weight_sram.sv */
// Weight memory
// Single-port synchronous SRAM with a loader write and a one-cycle read
`timescale 1ns/1ns
`include "stream_defs.svh"

module weight_sram (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  stream_pkg::mem_wr_t  wr_i,
    input  stream_pkg::mem_req_t req_i,
    output stream_pkg::mem_rsp_t rsp_o
);

    localparam int WORDS = 1 << `STREAM_ADDR_W;

    // Storage array, contents undefined until loaded
    logic [`STREAM_DATA_W-1:0] mem_q [WORDS];

    // Registered read port
    logic [`STREAM_DATA_W-1:0] rdata_q;
    logic                      rvalid_q;

    // Single port so a write only lands when no read is issued
    logic                      wr_en;

    assign wr_en = wr_i.we & ~req_i.ren;

    // Array write and read data capture
    always_ff @(posedge clk_i) begin
        if (wr_en) begin
            mem_q[wr_i.waddr] <= wr_i.wdata;
        end
        // Read data only updates on a request
        if (req_i.ren) begin
            rdata_q <= mem_q[req_i.raddr];
        end
    end

    // Response valid follows the request by one cycle
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rvalid_q <= 1'b0;
        end else begin
            rvalid_q <= req_i.ren;
        end
    end

    // Response bundle
    assign rsp_o.rvalid = rvalid_q;
    assign rsp_o.rdata  = rdata_q;

endmodule

/* src.f */
+incdir+logic
logic/stream_pkg.sv
logic/weight_sram.sv
logic/sync_fifo.sv
logic/mem_to_handshake_fifo.sv
logic/stream_top.sv
tb/stream_checker.sv
tb/tb_stream_top.sv

/* tb/stream_checker.sv */
// Stream checker
// Memory model and address sweep reference, compares every accepted word
`timescale 1ns/1ns
`include "stream_defs.svh"

module stream_checker (
    input  logic                       clk_i,
    input  logic                       rst_n_i,
    input  logic [3:0]                 test_id_i,
    input  logic                       en_i,
    input  logic                       flush_i,
    input  logic [`STREAM_ADDR_W-1:0]  bound_i,
    input  stream_pkg::mem_wr_t        mem_wr_i,
    input  logic                       data_ready_i,
    input  logic                       data_valid_i,
    input  logic [`STREAM_DATA_W-1:0]  data_i,
    input  logic [`STREAM_USAGE_W-1:0] usage_i,
    output int                         passed_o,
    output int                         failed_o,
    output int                         errors_o
);

    localparam int WORDS = 1 << `STREAM_ADDR_W;

    // Copy of the weight memory
    logic [`STREAM_DATA_W-1:0] model_mem [WORDS];
    // Address of the next word the consumer should get
    logic [`STREAM_ADDR_W-1:0] exp_addr = '0;
    logic [`STREAM_DATA_W-1:0] exp_data;

    // Last cycle stalled with valid high
    logic                      held = 1'b0;
    logic [`STREAM_DATA_W-1:0] held_data;
    logic                      flushed = 1'b0;

    logic [3:0] cur_id = 4'd0;
    int test_errs = 0;
    int test_words = 0;
    int n_pass = 0;
    int n_fail = 0;
    int n_err = 0;

    assign passed_o = n_pass;
    assign failed_o = n_fail;
    assign errors_o = n_err;

    function automatic string test_name(input logic [3:0] id);
        case (id)
            4'd1:    return "load_stream";
            4'd2:    return "wrap_bound";
            4'd3:    return "backpressure";
            4'd4:    return "flush_mid";
            4'd5:    return "disable";
            4'd6:    return "reload";
            default: return "idle";
        endcase
    endfunction

    task automatic log_mismatch(input string what, input logic [31:0] exp,
                                input logic [31:0] act);
        $display("ERR %s %s: expected %h, actual %h", test_name(cur_id), what, exp, act);
        test_errs++;
        n_err++;
    endtask

    task automatic raise_violation(input string msg);
        $display("Test %s: %s", test_name(cur_id), msg);
        test_errs++;
        n_err++;
    endtask

    // One summary line per finished test
    task automatic close_test();
        if (test_errs == 0) begin
            $display("Test %0d %s: PASS, %0d words", cur_id, test_name(cur_id), test_words);
            n_pass++;
        end else begin
            $display("Test %0d %s: FAIL, %0d errors", cur_id, test_name(cur_id), test_errs);
            n_fail++;
        end
        test_errs  = 0;
        test_words = 0;
    endtask

    always @(posedge clk_i) begin
        if (rst_n_i) begin
            if (test_id_i != cur_id) begin
                if (cur_id != 4'd0) begin
                    close_test();
                end
                cur_id = test_id_i;
            end
            // Loader writes only happen with en_i low
            if (mem_wr_i.we) begin
                model_mem[mem_wr_i.waddr] = mem_wr_i.wdata;
            end
            if (!en_i && data_valid_i) begin
                raise_violation("data_valid_o is high while en_i is low");
            end
            if (usage_i > `STREAM_DEPTH) begin
                raise_violation($sformatf("FIFO usage %0d is above the depth", usage_i));
            end
            if (flushed && usage_i != '0) begin
                log_mismatch("usage after flush", 32'd0, 32'(usage_i));
            end
            // Head word must not move while stalled
            if (held && !flushed && data_valid_i && data_i !== held_data) begin
                log_mismatch("held data", held_data, data_i);
            end
            // FIFO keeps order so one step of the sweep per accepted word
            if (data_valid_i && data_ready_i) begin
                exp_data = model_mem[exp_addr];
                if (data_i !== exp_data) begin
                    log_mismatch($sformatf("word at address %0d", exp_addr), exp_data, data_i);
                end
                exp_addr = (exp_addr == bound_i) ? '0 : exp_addr + 1'b1;
                test_words++;
            end
            if (flush_i) begin
                exp_addr = '0;
            end
            held      = data_valid_i && !data_ready_i;
            held_data = data_i;
            flushed   = flush_i;
        end
    end

endmodule

/* tb/tb_stream_top.sv */
// Weight stream testbench
// Seeded random load, sweep, back-pressure, flush, disable and reload runs
`timescale 1ns/1ns
`include "stream_defs.svh"

module tb_stream_top;

    localparam int WORDS = 1 << `STREAM_ADDR_W;

    // Cycle budget per test
    localparam int LOAD_CYC  = 300;
    localparam int WRAP_CYC  = 300;
    localparam int BP_CYC    = 600;
    localparam int FLUSH_CYC = 500;
    localparam int DIS_CYC   = 400;
    localparam int RELD_CYC  = 400;
    // Stall limit with 20% margin over the budgets
    localparam int LIMIT_CYC =
        (LOAD_CYC + WRAP_CYC + BP_CYC + FLUSH_CYC + DIS_CYC + RELD_CYC) * 6 / 5;

    logic                       clk = 1'b0;
    logic                       rst_n;
    logic                       en;
    logic                       flush;
    logic [`STREAM_ADDR_W-1:0]  bound;
    stream_pkg::mem_wr_t        mem_wr;
    logic                       data_ready;
    logic                       data_valid;
    logic [`STREAM_DATA_W-1:0]  data;
    logic [`STREAM_USAGE_W-1:0] usage;

    // Test number seen by the checker where 7 marks the end
    logic [3:0] test_id;
    // Percent chance of ready high per cycle
    int         ready_pct;
    int         xfer_cnt = 0;
    int         cycle_cnt = 0;
    int         n_pass;
    int         n_fail;
    int         n_err;

    always #50 clk = ~clk;

    stream_top dut_i (
        .clk_i              (clk),
        .rst_n_i            (rst_n),
        .en_i               (en),
        .flush_i            (flush),
        .addr_upper_bound_i (bound),
        .mem_wr_i           (mem_wr),
        .data_ready_i       (data_ready),
        .data_valid_o       (data_valid),
        .data_o             (data),
        .debug_fifo_usage_o (usage)
    );

    stream_checker chk_i (
        .clk_i        (clk),
        .rst_n_i      (rst_n),
        .test_id_i    (test_id),
        .en_i         (en),
        .flush_i      (flush),
        .bound_i      (bound),
        .mem_wr_i     (mem_wr),
        .data_ready_i (data_ready),
        .data_valid_i (data_valid),
        .data_i       (data),
        .usage_i      (usage),
        .passed_o     (n_pass),
        .failed_o     (n_fail),
        .errors_o     (n_err)
    );

    // Accepted downstream words
    always @(posedge clk) begin
        if (data_valid && data_ready) begin
            xfer_cnt <= xfer_cnt + 1;
        end
    end

    // Stall guard
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == LIMIT_CYC) begin
            $display("Run stalled: test %0d made no progress within %0d cycles",
                     test_id, LIMIT_CYC);
            $display("Simulation failed");
            $finish;
        end
    end

    function automatic int rand_between(input int lo, input int hi);
        return lo + int'($urandom % (hi - lo + 1));
    endfunction

    // One clock with strobes dropped and ready redrawn
    task automatic tick();
        @(posedge clk);
        flush      <= 1'b0;
        mem_wr.we  <= 1'b0;
        data_ready <= (($urandom % 100) < ready_pct);
    endtask

    task automatic start_test(input logic [3:0] id);
        tick();
        test_id <= id;
    endtask

    // One-cycle loader write
    task automatic write_word(input logic [`STREAM_ADDR_W-1:0] addr,
                              input logic [`STREAM_DATA_W-1:0] value);
        tick();
        mem_wr.we    <= 1'b1;
        mem_wr.waddr <= addr;
        mem_wr.wdata <= value;
    endtask

    // Wait for n more accepted words
    task automatic wait_words(input int n);
        int target;
        target = xfer_cnt + n;
        while (xfer_cnt < target) begin
            tick();
        end
    endtask

    initial begin
        int          b;
        logic [`STREAM_ADDR_W-1:0] waddr;
        logic [`STREAM_DATA_W-1:0] wdata;
        void'($urandom(32'h7f6b));
        rst_n      = 1'b0;
        en         = 1'b0;
        flush      = 1'b0;
        bound      = '1;
        mem_wr     = '0;
        data_ready = 1'b0;
        test_id    = 4'd0;
        ready_pct  = 100;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;

        // Full load followed by two passes over the whole memory
        start_test(4'd1);
        for (int a = 0; a < WORDS; a++) begin
            write_word(`STREAM_ADDR_W'(a), $urandom);
        end
        tick();
        en <= 1'b1;
        wait_words(2 * WORDS);

        // Shorter sweep restarted by a flush
        start_test(4'd2);
        b = rand_between(0, WORDS - 2);
        bound <= `STREAM_ADDR_W'(b);
        flush <= 1'b1;
        wait_words(3 * (b + 1));

        start_test(4'd3);
        ready_pct = 30;
        wait_words(100);

        // Flushes at random points
        start_test(4'd4);
        ready_pct = 50;
        repeat (6) begin
            wait_words(rand_between(3, 16));
            tick();
            flush <= 1'b1;
        end
        wait_words(8);

        // Enable dropped for a few cycles at a time
        start_test(4'd5);
        ready_pct = 70;
        repeat (6) begin
            wait_words(rand_between(4, 15));
            tick();
            en <= 1'b0;
            repeat (rand_between(2, 8)) tick();
            en <= 1'b1;
        end
        wait_words(10);

        // Rewrite part of the memory while idle
        start_test(4'd6);
        ready_pct = 100;
        en <= 1'b0;
        repeat (2) tick();
        repeat (16) begin
            waddr = `STREAM_ADDR_W'($urandom % WORDS);
            wdata = $urandom;
            write_word(waddr, wdata);
        end
        tick();
        bound <= '1;
        flush <= 1'b1;
        tick();
        en <= 1'b1;
        wait_words(2 * WORDS);

        start_test(4'd7);
        repeat (2) tick();
        @(negedge clk);
        $display("%0d tests passed, %0d failed, %0d errors", n_pass, n_fail, n_err);
        if (n_pass == 6 && n_fail == 0 && n_err == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule
